// File: dv/ladybird_clkgen.sv
`default_nettype none

// free running clock and power-on reset for the testbench
module ladybird_clkgen (
  output logic clk_o,
  output logic nrst_o
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 8;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  initial begin
    nrst_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    nrst_o <= 1'b1;  // released just after an edge
  end

endmodule

`default_nettype wire

// File: dv/ladybird_periph_props.sv
`default_nettype none

`include "ladybird_defs.svh"

module ladybird_periph_props (
  input wire logic                clk,
  input wire logic                nrst,
  input wire logic                req_i,
  input wire logic                we_i,
  input wire logic                ram_sel_i,
  input wire logic                gpio_sel_i,
  input wire logic                rvalid_i,
  input wire logic                fault_i,
  input wire logic [`LB_XLEN-1:0] rdata_i,
  input wire logic                irq_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;  // assertion failures so far

  //////////////////////////////////////////////////////////////////////
  // response stream
  //////////////////////////////////////////////////////////////////////

  // every read answers exactly two edges later, nothing else answers
  read_latency_a: assert property (@(posedge clk) disable iff (!nrst)
    rvalid_i == $past(req_i && !we_i, 2))
    else begin
      $error("rvalid_o does not follow a read request by two cycles");
      fail_count++;
    end

  fault_data_a: assert property (@(posedge clk) disable iff (!nrst)
    fault_i |-> (rvalid_i && rdata_i == '0))
    else begin
      $error("fault_o without rvalid_o or with nonzero rdata_o");
      fail_count++;
    end

  //////////////////////////////////////////////////////////////////////
  // decode and interrupt
  //////////////////////////////////////////////////////////////////////

  one_hot_sel_a: assert property (@(posedge clk) disable iff (!nrst)
    !(ram_sel_i && gpio_sel_i))
    else begin
      $error("ram and gpio selected in the same cycle");
      fail_count++;
    end

  irq_reset_a: assert property (@(posedge clk) $past(!nrst) |-> !irq_i)
    else begin
      $error("irq_o high while in reset");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: dv/ladybird_periph_tb.sv
`default_nettype none

`include "ladybird_defs.svh"

module ladybird_periph_tb
  import ladybird_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_PINS, OP_DONE, OP_OUT, OP_IRQ} op_e;

  typedef struct packed {
    op_e                   op;
    int                    test;
    logic [`LB_XLEN-1:0]   addr;
    logic [`LB_XLEN-1:0]   data;
    logic [`LB_N_GPIO-1:0] pins;
    logic [`LB_XLEN-1:0]   exp;   // gpio_o or irq_o for check rows
  } step_t;

  typedef struct packed {
    logic [`LB_XLEN-1:0] data;
    logic                fault;
    int                  issued;  // cycle the read was driven
  } resp_t;

  localparam int unsigned         SEED      = 32'he1aa_f3d0;
  localparam int                  RAM_WORDS = 1 << `LB_RAM_ADDR_W;
  localparam logic [`LB_XLEN-1:0] RAM_BASE  = `LB_RAM_BASE;
  localparam logic [`LB_XLEN-1:0] GPIO_BASE = `LB_GPIO_BASE;

  logic                  clk, nrst;
  logic                  req, we, complete;
  logic [`LB_XLEN-1:0]   addr, wdata, rdata;
  logic                  rvalid, fault, irq;
  logic [`LB_N_GPIO-1:0] gpio_in, gpio_out;

  step_t                 steps[$];
  resp_t                 exp_q[$];
  resp_t                 head;
  logic [`LB_XLEN-1:0]   ram_m [RAM_WORDS];
  logic [`LB_XLEN-1:0]   ram_addrs[$];
  logic [`LB_N_GPIO-1:0] in_m, out_m, mask_m, pending_m;
  int                    cyc = 0;
  int                    cycle_limit = 0;
  int                    errors = 0;
  int                    checks = 0;
  int                    ntests = 0;
  int                    cur_test, err_mark;

  ladybird_clkgen u_clkgen (.clk_o(clk), .nrst_o(nrst));

  ladybird_periph u_ladybird_periph (
    .clk(clk), .nrst(nrst), .req_i(req), .we_i(we), .addr_i(addr), .wdata_i(wdata),
    .rvalid_o(rvalid), .fault_o(fault), .rdata_o(rdata), .gpio_i(gpio_in),
    .gpio_o(gpio_out), .complete_i(complete), .irq_o(irq)
  );

  // router selects are visible as wires in the top level
  bind ladybird_periph ladybird_periph_props u_props (
    .clk(clk), .nrst(nrst), .req_i(req_i), .we_i(we_i), .ram_sel_i(ram_sel),
    .gpio_sel_i(gpio_sel), .rvalid_i(rvalid_o), .fault_i(fault_o), .rdata_i(rdata_o),
    .irq_i(irq_o)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [`LB_XLEN-1:0] gpio_addr(input gpio_reg_e r);
    return GPIO_BASE | {28'h0, r, 2'b00};
  endfunction

  function automatic void model_write(input logic [`LB_XLEN-1:0] a,
                                      input logic [`LB_XLEN-1:0] d);
    if (a[31:28] == RAM_BASE[31:28]) begin
      ram_m[a[`LB_RAM_ADDR_W+1:2]] = d;
    end else if (a[31:28] == GPIO_BASE[31:28]) begin
      case (gpio_reg_e'(a[3:2]))
        REG_OUT:     out_m = d[`LB_N_GPIO-1:0];
        REG_PENDING: pending_m = pending_m & ~d[`LB_N_GPIO-1:0];  // w1c
        REG_MASK:    mask_m = d[`LB_N_GPIO-1:0];
        default:     ;
      endcase
    end  // unmapped writes vanish
  endfunction

  function automatic void predict_read(input logic [`LB_XLEN-1:0] a,
                                       output logic [`LB_XLEN-1:0] d, output logic f);
    d = '0;
    f = 1'b0;
    if (a[31:28] == RAM_BASE[31:28]) begin
      d = ram_m[a[`LB_RAM_ADDR_W+1:2]];
    end else if (a[31:28] == GPIO_BASE[31:28]) begin
      case (gpio_reg_e'(a[3:2]))
        REG_IN:      d[`LB_N_GPIO-1:0] = in_m;
        REG_OUT:     d[`LB_N_GPIO-1:0] = out_m;
        REG_PENDING: d[`LB_N_GPIO-1:0] = pending_m;
        default:     d[`LB_N_GPIO-1:0] = mask_m;
      endcase
    end else begin
      f = 1'b1;
    end
  endfunction

  // pins held long enough to pass the synchronizer
  function automatic void model_pins(input logic [`LB_N_GPIO-1:0] p);
    pending_m = pending_m | (p & ~in_m & mask_m);
    in_m = p;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checks and reporting
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input logic [`LB_XLEN-1:0] expv,
                            input logic [`LB_XLEN-1:0] actv);
    checks++;
    if (actv !== expv) begin
      $display("ERROR %s expected 0x%h got 0x%h", name, expv, actv);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expv, input logic actv);
    checks++;
    if (actv !== expv) begin
      $display("ERROR %s expected 0x%h got 0x%h", name, expv, actv);
      errors++;
    end
  endtask

  task automatic check_gpio(input string name, input logic [`LB_N_GPIO-1:0] expv,
                            input logic [`LB_N_GPIO-1:0] actv);
    checks++;
    if (actv !== expv) begin
      $display("ERROR %s expected 0x%h got 0x%h", name, expv, actv);
      errors++;
    end
  endtask

  function automatic string test_name(input int n);
    case (n)
      0:       return "reset state";
      1:       return "ram write and read-back";
      2:       return "gpio output register";
      3:       return "gpio input synchronizer";
      4:       return "masked edge interrupts";
      5:       return "completion clear";
      default: return "unmapped and interleaved reads";
    endcase
  endfunction

  task automatic report_test(input int n, input int errs);
    if (errs == 0) begin
      $display("test %0d (%s): ok", n, test_name(n));
    end else begin
      $display("test %0d (%s): failed with %0d errors", n, test_name(n), errs);
    end
    ntests++;
  endtask

  // responses are checked where rvalid is stable, between edges
  always @(negedge clk) begin
    if (nrst && rvalid) begin
      if (exp_q.size() == 0) begin
        $display("read response arrived with no read outstanding");
        errors++;
      end else begin
        head = exp_q.pop_front();
        check_word("rdata_o", head.data, rdata);
        check_flag("fault_o", head.fault, fault);
        if (cyc - head.issued != 2) begin
          $display("read answered %0d cycles after its request, not 2", cyc - head.issued);
          errors++;
        end
      end
    end
  end

  always @(posedge clk) cyc <= cyc + 1;

  //////////////////////////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////////////////////////

  function automatic void add_step(input op_e op, input int test,
                                   input logic [`LB_XLEN-1:0] a, input logic [`LB_XLEN-1:0] d,
                                   input logic [`LB_N_GPIO-1:0] p,
                                   input logic [`LB_XLEN-1:0] e);
    step_t s;
    s.op   = op;
    s.test = test;
    s.addr = a;
    s.data = d;
    s.pins = p;
    s.exp  = e;
    steps.push_back(s);
  endfunction

  task automatic build_table();
    logic [`LB_RAM_ADDR_W-1:0] idx;
    logic [`LB_XLEN-1:0]       a;
    add_step(OP_OUT, 0, '0, '0, '0, 32'h0);
    add_step(OP_IRQ, 0, '0, '0, '0, 32'h0);
    add_step(OP_RD,  0, gpio_addr(REG_MASK), '0, '0, '0);
    for (int n = 0; n < 8; n++) begin
      idx = `LB_RAM_ADDR_W'($urandom_range(0, RAM_WORDS - 1));
      a   = RAM_BASE | {21'h0, idx, 2'b00};
      ram_addrs.push_back(a);
      add_step(OP_WR, 1, a, $urandom(), '0, '0);
    end
    for (int n = 0; n < 8; n++) begin
      add_step(OP_RD, 1, ram_addrs[n], '0, '0, '0);  // back to back
    end
    add_step(OP_WR,   2, gpio_addr(REG_OUT), 32'h0000_00a5, '0, '0);
    add_step(OP_OUT,  2, '0, '0, '0, 32'h0000_00a5);
    add_step(OP_RD,   2, gpio_addr(REG_OUT), '0, '0, '0);
    add_step(OP_PINS, 3, '0, '0, 8'h3c, '0);
    add_step(OP_RD,   3, gpio_addr(REG_IN), '0, '0, '0);
    add_step(OP_WR,   4, gpio_addr(REG_MASK), 32'h0000_000f, '0, '0);
    add_step(OP_PINS, 4, '0, '0, 8'h00, '0);
    add_step(OP_PINS, 4, '0, '0, 8'hff, '0);  // upper four rise unmasked
    add_step(OP_RD,   4, gpio_addr(REG_PENDING), '0, '0, '0);
    add_step(OP_IRQ,  4, '0, '0, '0, 32'h1);
    add_step(OP_WR,   4, gpio_addr(REG_PENDING), 32'h0000_0005, '0, '0);
    add_step(OP_RD,   4, gpio_addr(REG_PENDING), '0, '0, '0);
    add_step(OP_IRQ,  4, '0, '0, '0, 32'h1);
    add_step(OP_DONE, 5, '0, '0, '0, '0);
    add_step(OP_IRQ,  5, '0, '0, '0, 32'h0);
    add_step(OP_RD,   5, gpio_addr(REG_PENDING), '0, '0, '0);
    // same low bits as a ram word that is read back below
    add_step(OP_WR,   6, 32'h4000_0000 | (ram_addrs[0] & 32'h0fff_ffff), 32'hdead_beef,
             '0, '0);
    add_step(OP_RD,   6, 32'h5000_0000, '0, '0, '0);
    add_step(OP_RD,   6, ram_addrs[0], '0, '0, '0);
    add_step(OP_RD,   6, gpio_addr(REG_OUT), '0, '0, '0);
    add_step(OP_RD,   6, ram_addrs[1], '0, '0, '0);
    add_step(OP_RD,   6, 32'h0000_0010, '0, '0, '0);
    add_step(OP_RD,   6, gpio_addr(REG_MASK), '0, '0, '0);
    add_step(OP_RD,   6, ram_addrs[2], '0, '0, '0);
  endtask

  task automatic drive_idle();
    req      = 1'b0;
    we       = 1'b0;
    addr     = '0;
    wdata    = '0;
    complete = 1'b0;
  endtask

  task automatic apply_step(input step_t s);
    resp_t r;
    @(negedge clk);
    drive_idle();
    case (s.op)
      OP_WR: begin
        req   = 1'b1;
        we    = 1'b1;
        addr  = s.addr;
        wdata = s.data;
        model_write(s.addr, s.data);
      end
      OP_RD: begin
        req  = 1'b1;
        addr = s.addr;
        predict_read(s.addr, r.data, r.fault);
        r.issued = cyc;
        exp_q.push_back(r);
      end
      OP_PINS: begin
        gpio_in = s.pins;
        model_pins(s.pins);
        repeat (3) @(negedge clk);  // sync, edge detect, pending
      end
      OP_DONE: begin
        complete  = 1'b1;
        pending_m = '0;
      end
      OP_OUT:  check_gpio("gpio_o", s.exp[`LB_N_GPIO-1:0], gpio_out);
      default: check_flag("irq_o", s.exp[0], irq);
    endcase
  endtask

  task automatic drain_reads();
    @(negedge clk);
    drive_idle();
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    drive_idle();
    gpio_in   = '0;
    in_m      = '0;
    out_m     = '0;
    mask_m    = '0;
    pending_m = '0;
    void'($urandom(SEED));
    build_table();
    cycle_limit = steps.size() * 10 + 200;
    wait (nrst === 1'b1);
    cur_test = steps[0].test;
    err_mark = 0;
    foreach (steps[i]) begin
      if (steps[i].test != cur_test) begin
        drain_reads();
        report_test(cur_test, errors - err_mark);
        cur_test = steps[i].test;
        err_mark = errors;
      end
      apply_step(steps[i]);
    end
    drain_reads();
    report_test(cur_test, errors - err_mark);
    if (u_ladybird_periph.u_props.fail_count != 0) begin
      $display("%0d assertion failures in the bound checker",
               u_ladybird_periph.u_props.fail_count);
      errors += int'(u_ladybird_periph.u_props.fail_count);
    end
    $display("%0d tests, %0d checks, %0d errors", ntests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    wait (cycle_limit != 0);
    while (cyc < cycle_limit) @(posedge clk);
    $display("run did not finish within %0d cycles, %0d reads outstanding",
             cycle_limit, exp_q.size());
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/ladybird_block_ram.sv
`default_nettype none

`include "ladybird_defs.svh"

// scratchpad ram with a two stage read
module ladybird_block_ram (
  input  wire logic                      clk,
  input  wire logic                      nrst,
  input  wire logic                      sel_i,
  input  wire logic                      we_i,
  input  wire logic [`LB_RAM_ADDR_W-1:0] word_addr_i,
  input  wire logic [`LB_XLEN-1:0]       wdata_i,
  output logic      [`LB_XLEN-1:0]       rdata_o
);

  localparam int DEPTH = 1 << `LB_RAM_ADDR_W;

  logic [`LB_XLEN-1:0]       mem [DEPTH];
  logic [`LB_RAM_ADDR_W-1:0] raddr_q;  // stage 1 address
  logic                      rd_en_q;  // stage 1 read strobe
  logic [`LB_XLEN-1:0]       rdata_q;  // stage 2 data

  //////////////////////////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (sel_i && we_i) begin
      mem[word_addr_i] <= wdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read pipeline
  //////////////////////////////////////////////////////////////////////

  // first edge captures the address
  always_ff @(posedge clk) begin
    if (!nrst) begin
      rd_en_q <= 1'b0;
    end else begin
      rd_en_q <= sel_i && !we_i;
    end
  end

  always_ff @(posedge clk) begin
    if (sel_i && !we_i) begin
      raddr_q <= word_addr_i;
    end
  end

  // second edge fetches the word, holds otherwise
  always_ff @(posedge clk) begin
    if (rd_en_q) begin
      rdata_q <= mem[raddr_q];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: hw/ladybird_gpio.sv
`default_nettype none

`include "ladybird_defs.svh"

module ladybird_gpio
  import ladybird_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  nrst,
  input  wire logic                  sel_i,
  input  wire logic                  we_i,
  input  wire gpio_reg_e             reg_i,
  input  wire logic [`LB_XLEN-1:0]   wdata_i,
  output logic      [`LB_XLEN-1:0]   rdata_o,
  input  wire logic [`LB_N_GPIO-1:0] gpio_i,
  output logic      [`LB_N_GPIO-1:0] gpio_o,
  input  wire logic                  complete_i,
  output logic                       irq_o
);

  logic [`LB_N_GPIO-1:0] sync1_q;    // first synchronizer flop
  logic [`LB_N_GPIO-1:0] sync2_q;    // synced pin value
  logic [`LB_N_GPIO-1:0] prev_q;     // for edge detect
  logic [`LB_N_GPIO-1:0] rise;
  logic [`LB_N_GPIO-1:0] out_q;
  logic [`LB_N_GPIO-1:0] mask_q;
  logic [`LB_N_GPIO-1:0] pending_q;
  logic [`LB_N_GPIO-1:0] pending_clr;
  logic [`LB_N_GPIO-1:0] pending_d;
  logic                  wr;
  logic [`LB_XLEN-1:0]   rd_word;
  logic [`LB_XLEN-1:0]   rdata_q;

  //////////////////////////////////////////////////////////////////////
  // input synchronizer and edge detect
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!nrst) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  assign rise = sync2_q & ~prev_q;

  //////////////////////////////////////////////////////////////////////
  // register writes and pending logic
  //////////////////////////////////////////////////////////////////////

  assign wr = sel_i && we_i;

  always_comb begin
    pending_clr = '0;
    if (complete_i) begin
      pending_clr = '1;  // completion drops everything
    end else if (wr && reg_i == REG_PENDING) begin
      pending_clr = wdata_i[`LB_N_GPIO-1:0];
    end
    // a fresh edge beats any clear
    pending_d = (pending_q & ~pending_clr) | (rise & mask_q);
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      out_q     <= '0;
      mask_q    <= '0;
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
      if (wr && reg_i == REG_OUT) begin
        out_q <= wdata_i[`LB_N_GPIO-1:0];
      end
      if (wr && reg_i == REG_MASK) begin
        mask_q <= wdata_i[`LB_N_GPIO-1:0];
      end
    end
  end

  assign gpio_o = out_q;
  assign irq_o  = |pending_q;

  //////////////////////////////////////////////////////////////////////
  // read back, one register stage
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_word = '0;  // upper bits stay zero
    unique case (reg_i)
      REG_IN:      rd_word[`LB_N_GPIO-1:0] = sync2_q;
      REG_OUT:     rd_word[`LB_N_GPIO-1:0] = out_q;
      REG_PENDING: rd_word[`LB_N_GPIO-1:0] = pending_q;
      REG_MASK:    rd_word[`LB_N_GPIO-1:0] = mask_q;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sel_i && !we_i) begin
      rdata_q <= rd_word;
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: hw/ladybird_periph.sv
`default_nettype none

`include "ladybird_defs.svh"

module ladybird_periph
  import ladybird_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  nrst,
  // core data port
  input  wire logic                  req_i,
  input  wire logic                  we_i,
  input  wire logic [`LB_XLEN-1:0]   addr_i,
  input  wire logic [`LB_XLEN-1:0]   wdata_i,
  output logic                       rvalid_o,
  output logic                       fault_o,
  output logic      [`LB_XLEN-1:0]   rdata_o,
  // pins and interrupt
  input  wire logic [`LB_N_GPIO-1:0] gpio_i,
  output logic      [`LB_N_GPIO-1:0] gpio_o,
  input  wire logic                  complete_i,
  output logic                       irq_o
);

  logic                      ram_sel;
  logic                      gpio_sel;
  logic                      we;
  logic [`LB_RAM_ADDR_W-1:0] ram_addr;
  gpio_reg_e                 gpio_reg;
  logic [`LB_XLEN-1:0]       wdata;
  logic [`LB_XLEN-1:0]       ram_rdata;   // lands two cycles after select
  logic [`LB_XLEN-1:0]       gpio_rdata;  // lands one cycle after select

  ladybird_periph_router u_router (
    .clk          (clk),
    .nrst         (nrst),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .wdata_i      (wdata_i),
    .ram_sel_o    (ram_sel),
    .gpio_sel_o   (gpio_sel),
    .we_o         (we),
    .ram_addr_o   (ram_addr),
    .gpio_reg_o   (gpio_reg),
    .wdata_o      (wdata),
    .ram_rdata_i  (ram_rdata),
    .gpio_rdata_i (gpio_rdata),
    .rvalid_o     (rvalid_o),
    .fault_o      (fault_o),
    .rdata_o      (rdata_o)
  );

  ladybird_block_ram u_ram (
    .clk         (clk),
    .nrst        (nrst),
    .sel_i       (ram_sel),
    .we_i        (we),
    .word_addr_i (ram_addr),
    .wdata_i     (wdata),
    .rdata_o     (ram_rdata)
  );

  ladybird_gpio u_gpio (
    .clk        (clk),
    .nrst       (nrst),
    .sel_i      (gpio_sel),
    .we_i       (we),
    .reg_i      (gpio_reg),
    .wdata_i    (wdata),
    .rdata_o    (gpio_rdata),
    .gpio_i     (gpio_i),
    .gpio_o     (gpio_o),
    .complete_i (complete_i),
    .irq_o      (irq_o)
  );

endmodule

`default_nettype wire

// File: hw/ladybird_periph_router.sv
`default_nettype none

`include "ladybird_defs.svh"

module ladybird_periph_router
  import ladybird_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      nrst,
  // core side
  input  wire logic                      req_i,
  input  wire logic                      we_i,
  input  wire logic [`LB_XLEN-1:0]       addr_i,
  input  wire logic [`LB_XLEN-1:0]       wdata_i,
  // toward the peripherals
  output logic                           ram_sel_o,
  output logic                           gpio_sel_o,
  output logic                           we_o,
  output logic      [`LB_RAM_ADDR_W-1:0] ram_addr_o,
  output gpio_reg_e                      gpio_reg_o,
  output logic      [`LB_XLEN-1:0]       wdata_o,
  input  wire logic [`LB_XLEN-1:0]       ram_rdata_i,
  input  wire logic [`LB_XLEN-1:0]       gpio_rdata_i,
  // response stream
  output logic                           rvalid_o,
  output logic                           fault_o,
  output logic      [`LB_XLEN-1:0]       rdata_o
);

  localparam logic [`LB_XLEN-1:0] RAM_BASE  = `LB_RAM_BASE;
  localparam logic [`LB_XLEN-1:0] GPIO_BASE = `LB_GPIO_BASE;

  bus_target_e         target;
  logic                rd_vld1_q, rd_vld2_q;
  bus_target_e         tag1_q, tag2_q;
  logic [`LB_XLEN-1:0] gpio_rdata_q;  // gpio aligned to latency two

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    target = TGT_NONE;
    if (addr_i[31:28] == RAM_BASE[31:28]) begin
      target = TGT_RAM;
    end else if (addr_i[31:28] == GPIO_BASE[31:28]) begin
      target = TGT_GPIO;
    end
  end

  assign ram_sel_o  = req_i && (target == TGT_RAM);
  assign gpio_sel_o = req_i && (target == TGT_GPIO);
  assign we_o       = we_i;
  assign ram_addr_o = addr_i[`LB_RAM_ADDR_W+1:2];
  assign gpio_reg_o = gpio_reg_e'(addr_i[3:2]);
  assign wdata_o    = wdata_i;

  //////////////////////////////////////////////////////////////////////
  // read tag pipeline
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!nrst) begin
      rd_vld1_q <= 1'b0;
      rd_vld2_q <= 1'b0;
    end else begin
      rd_vld1_q <= req_i && !we_i;  // writes never answer
      rd_vld2_q <= rd_vld1_q;
    end
  end

  always_ff @(posedge clk) begin
    tag1_q       <= target;
    tag2_q       <= tag1_q;
    gpio_rdata_q <= gpio_rdata_i;
  end

  //////////////////////////////////////////////////////////////////////
  // response combine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rvalid_o = rd_vld2_q;
    fault_o  = 1'b0;
    rdata_o  = '0;
    if (rd_vld2_q) begin
      unique case (tag2_q)
        TGT_RAM:  rdata_o = ram_rdata_i;
        TGT_GPIO: rdata_o = gpio_rdata_q;
        default:  fault_o = 1'b1;  // unmapped, data stays zero
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/ladybird_pkg.sv
`default_nettype none

package ladybird_pkg;

  // where a decoded request goes
  typedef enum logic [1:0] {
    TGT_NONE = 2'd0,  // unmapped, reads fault
    TGT_RAM  = 2'd1,
    TGT_GPIO = 2'd2
  } bus_target_e;

  // gpio register index from addr[3:2]
  typedef enum logic [1:0] {
    REG_IN      = 2'd0,  // synced pins, read only
    REG_OUT     = 2'd1,  // output latch
    REG_PENDING = 2'd2,  // pending irqs, w1c
    REG_MASK    = 2'd3   // irq enable
  } gpio_reg_e;

endpackage

`default_nettype wire

// File: include/ladybird_defs.svh
`ifndef LADYBIRD_DEFS_SVH
`define LADYBIRD_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// bus and peripheral sizes
//////////////////////////////////////////////////////////////////////

`define LB_XLEN         32  // data and address width
`define LB_RAM_ADDR_W   9   // 512 words of scratchpad
`define LB_N_GPIO       8   // gpio inputs and outputs

//////////////////////////////////////////////////////////////////////
// address map
//////////////////////////////////////////////////////////////////////

// regions decoded on addr[31:28]
// ram word index sits in addr[10:2]
// gpio register index sits in addr[3:2]
`define LB_RAM_BASE     32'h2000_0000
`define LB_GPIO_BASE    32'h3000_0000

`endif

// File: ladybird_periph.f
+incdir+include
hw/ladybird_pkg.sv
hw/ladybird_block_ram.sv
hw/ladybird_gpio.sv
hw/ladybird_periph_router.sv
hw/ladybird_periph.sv
dv/ladybird_clkgen.sv
dv/ladybird_periph_props.sv
dv/ladybird_periph_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ladybird peripheral testbench with verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=ladybird_sim
LOG=sim.log

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f ladybird_periph.f --top-module ladybird_periph_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
